//--- aluCluster.f
+incdir+rtl
rtl/aluClusterPkg.sv
rtl/reservationStation.sv
rtl/executeUnit.sv
rtl/aluCluster.sv
verification/aluCluster_asserts.sv
verification/aluClusterTb.sv

//--- rtl/aluCluster.sv
`timescale 1ns/100ps
`default_nettype none

module aluCluster (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    rdy,
    input  wire logic                    dispatchValid,
    input  wire aluClusterPkg::dispatchT dispatch,
    input  wire aluClusterPkg::cdbT      extCdb,
    output logic                         full,
    output aluClusterPkg::execResultT    exec,
    output aluClusterPkg::cdbT           cdbBus
);

    logic                      issueValid;
    aluClusterPkg::issueT      issue;
    aluClusterPkg::execResultT result;

    // an external result takes the bus, the own result still reaches the station directly
    assign cdbBus = extCdb.valid ? extCdb : result.cdb;
    assign exec   = result;

    reservationStation rs (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdbBus        (cdbBus),
        .selfCdb       (result.cdb),
        .full          (full),
        .issueValid    (issueValid),
        .issue         (issue)
    );

    executeUnit eu (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueValid (issueValid),
        .issue      (issue),
        .result     (result)
    );

endmodule

`default_nettype wire

//--- rtl/aluClusterPkg.sv
`default_nettype none

`include "aluCluster_settings.svh"

package aluClusterPkg;

    typedef logic [`DATA_W-1:0] dataT;
    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [`TAG_W-1:0]  tagT;

    // upper immediate, jumps, branches, then immediate and register ALU forms
    typedef enum logic [5:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND
    } aluOpT;

    typedef enum logic [1:0] {
        FREE,
        WAITING,
        READY
    } slotStateT;

    // value is only meaningful once ready is set, until then the operand waits on tag
    typedef struct packed {
        logic ready;
        tagT  tag;
        dataT value;
    } operandT;

    typedef struct packed {
        aluOpT   op;
        addrT    pc;
        dataT    imm;
        tagT     rd;
        operandT src1;
        operandT src2;
    } dispatchT;

    typedef struct packed {
        aluOpT op;
        addrT  pc;
        dataT  imm;
        tagT   rd;
        dataT  rs1Val;
        dataT  rs2Val;
    } issueT;

    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT value;
    } cdbT;

    // jump and nextPc go to the reorder buffer only
    typedef struct packed {
        cdbT  cdb;
        logic jump;
        addrT nextPc;
    } execResultT;

endpackage

`default_nettype wire

//--- rtl/aluCluster_settings.svh
`ifndef ALU_CLUSTER_SETTINGS_SVH
`define ALU_CLUSTER_SETTINGS_SVH

// operand and result width
`define DATA_W 32

// pc width
`define ADDR_W 32

// rename tag width, 16 tags in flight
`define TAG_W 4

`define RS_DEPTH 4

`endif

//--- rtl/executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rdy,
    input  wire logic                 issueValid,
    input  wire aluClusterPkg::issueT issue,
    output aluClusterPkg::execResultT result
);

    aluClusterPkg::dataT rs1;
    aluClusterPkg::dataT rs2;
    aluClusterPkg::dataT imm;
    aluClusterPkg::addrT pcPlus4;
    aluClusterPkg::addrT pcPlusImm;

    aluClusterPkg::dataT aluValue;
    logic                takeJump;
    logic                branchTaken;
    aluClusterPkg::addrT target;

    logic                validQ;
    aluClusterPkg::tagT  tagQ;
    aluClusterPkg::dataT valueQ;
    logic                jumpQ;
    aluClusterPkg::addrT nextPcQ;

    assign rs1       = issue.rs1Val;
    assign rs2       = issue.rs2Val;
    assign imm       = issue.imm;
    assign pcPlus4   = issue.pc + aluClusterPkg::addrT'(4);
    assign pcPlusImm = issue.pc + aluClusterPkg::addrT'(imm);

    always_comb begin
        aluValue    = '0;
        takeJump    = 1'b0;
        branchTaken = 1'b0;
        target      = pcPlus4;
        case (issue.op)
            aluClusterPkg::OP_LUI:   aluValue = imm;
            aluClusterPkg::OP_AUIPC: aluValue = aluClusterPkg::dataT'(issue.pc) + imm;
            aluClusterPkg::OP_JAL: begin
                aluValue = aluClusterPkg::dataT'(pcPlus4);
                takeJump = 1'b1;
                target   = pcPlusImm;
            end
            aluClusterPkg::OP_JALR: begin
                aluValue = aluClusterPkg::dataT'(pcPlus4);
                takeJump = 1'b1;
                target   = aluClusterPkg::addrT'(rs1 + imm) & ~aluClusterPkg::addrT'(1);
            end
            aluClusterPkg::OP_BEQ:   branchTaken = rs1 == rs2;
            aluClusterPkg::OP_BNE:   branchTaken = rs1 != rs2;
            aluClusterPkg::OP_BLT:   branchTaken = $signed(rs1) < $signed(rs2);
            aluClusterPkg::OP_BGE:   branchTaken = $signed(rs1) >= $signed(rs2);
            aluClusterPkg::OP_BLTU:  branchTaken = rs1 < rs2;
            aluClusterPkg::OP_BGEU:  branchTaken = rs1 >= rs2;
            aluClusterPkg::OP_ADDI:  aluValue = rs1 + imm;
            aluClusterPkg::OP_SLTI:  aluValue = aluClusterPkg::dataT'($signed(rs1) < $signed(imm));
            aluClusterPkg::OP_SLTIU: aluValue = aluClusterPkg::dataT'(rs1 < imm);
            aluClusterPkg::OP_XORI:  aluValue = rs1 ^ imm;
            aluClusterPkg::OP_ORI:   aluValue = rs1 | imm;
            aluClusterPkg::OP_ANDI:  aluValue = rs1 & imm;
            aluClusterPkg::OP_SLLI:  aluValue = rs1 << imm[4:0];
            aluClusterPkg::OP_SRLI:  aluValue = rs1 >> imm[4:0];
            aluClusterPkg::OP_SRAI:  aluValue = $signed(rs1) >>> imm[4:0];
            aluClusterPkg::OP_ADD:   aluValue = rs1 + rs2;
            aluClusterPkg::OP_SUB:   aluValue = rs1 - rs2;
            aluClusterPkg::OP_SLL:   aluValue = rs1 << rs2[4:0];
            aluClusterPkg::OP_SLT:   aluValue = aluClusterPkg::dataT'($signed(rs1) < $signed(rs2));
            aluClusterPkg::OP_SLTU:  aluValue = aluClusterPkg::dataT'(rs1 < rs2);
            aluClusterPkg::OP_XOR:   aluValue = rs1 ^ rs2;
            aluClusterPkg::OP_SRL:   aluValue = rs1 >> rs2[4:0];
            aluClusterPkg::OP_SRA:   aluValue = $signed(rs1) >>> rs2[4:0];
            aluClusterPkg::OP_OR:    aluValue = rs1 | rs2;
            aluClusterPkg::OP_AND:   aluValue = rs1 & rs2;
            default:                 aluValue = '0;
        endcase
        // a taken branch redirects to pc plus imm, otherwise fall through
        if (branchTaken) begin
            takeJump = 1'b1;
            target   = pcPlusImm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (rdy) begin
            validQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueValid) begin
            tagQ    <= issue.rd;
            valueQ  <= aluValue;
            jumpQ   <= takeJump;
            nextPcQ <= target;
        end
    end

    assign result = '{cdb: '{valid: validQ, tag: tagQ, value: valueQ},
                      jump: jumpQ, nextPc: nextPcQ};

endmodule

`default_nettype wire

//--- rtl/reservationStation.sv
`timescale 1ns/100ps
`default_nettype none

`include "aluCluster_settings.svh"

module reservationStation (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rdy,
    input  wire logic                   dispatchValid,
    input  wire aluClusterPkg::dispatchT dispatch,
    input  wire aluClusterPkg::cdbT      cdbBus,
    input  wire aluClusterPkg::cdbT      selfCdb,
    output logic                        full,
    output logic                        issueValid,
    output aluClusterPkg::issueT        issue
);

    localparam int SLOT_W = $clog2(`RS_DEPTH);

    aluClusterPkg::slotStateT state [`RS_DEPTH];
    // age counts the younger entries still held, so the oldest has the largest age
    logic [SLOT_W-1:0]        age   [`RS_DEPTH];
    aluClusterPkg::dispatchT  entry [`RS_DEPTH];

    aluClusterPkg::operandT   nextSrc1 [`RS_DEPTH];
    aluClusterPkg::operandT   nextSrc2 [`RS_DEPTH];
    aluClusterPkg::operandT   dispSrc1;
    aluClusterPkg::operandT   dispSrc2;

    logic              accept;
    logic              pickValid;
    logic [SLOT_W-1:0] pick;
    logic [SLOT_W-1:0] pickAge;
    logic [SLOT_W-1:0] freeIdx;

    // the external bus wins if both carry the same tag
    function automatic aluClusterPkg::operandT snoop(aluClusterPkg::operandT opnd,
                                                     aluClusterPkg::cdbT busA,
                                                     aluClusterPkg::cdbT busB);
        aluClusterPkg::operandT res;
        res = opnd;
        if (!opnd.ready && busA.valid && busA.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = busA.value;
        end else if (!opnd.ready && busB.valid && busB.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = busB.value;
        end
        return res;
    endfunction

    always_comb begin
        dispSrc1 = snoop(dispatch.src1, cdbBus, selfCdb);
        dispSrc2 = snoop(dispatch.src2, cdbBus, selfCdb);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            nextSrc1[i] = snoop(entry[i].src1, cdbBus, selfCdb);
            nextSrc2[i] = snoop(entry[i].src2, cdbBus, selfCdb);
        end
    end

    // oldest ready slot and lowest free slot
    always_comb begin
        pickValid = 1'b0;
        pick      = '0;
        pickAge   = '0;
        freeIdx   = '0;
        full      = 1'b1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (state[i] == aluClusterPkg::READY && (!pickValid || age[i] > pickAge)) begin
                pickValid = 1'b1;
                pick      = SLOT_W'(i);
                pickAge   = age[i];
            end
        end
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == aluClusterPkg::FREE) begin
                freeIdx = SLOT_W'(i);
                full    = 1'b0;
            end
        end
    end

    assign accept = dispatchValid && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                state[i] <= aluClusterPkg::FREE;
                age[i]   <= '0;
            end
        end else if (rdy) begin
            issueValid <= pickValid;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (pickValid && pick == SLOT_W'(i)) begin
                    state[i] <= aluClusterPkg::FREE;
                end else if (state[i] != aluClusterPkg::FREE) begin
                    state[i] <= (nextSrc1[i].ready && nextSrc2[i].ready) ?
                                aluClusterPkg::READY : aluClusterPkg::WAITING;
                    age[i]   <= age[i] + SLOT_W'(accept)
                              - SLOT_W'(pickValid && age[i] > pickAge);
                end else if (accept && freeIdx == SLOT_W'(i)) begin
                    state[i] <= (dispSrc1.ready && dispSrc2.ready) ?
                                aluClusterPkg::READY : aluClusterPkg::WAITING;
                    age[i]   <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (state[i] != aluClusterPkg::FREE) begin
                    entry[i].src1 <= nextSrc1[i];
                    entry[i].src2 <= nextSrc2[i];
                end else if (accept && freeIdx == SLOT_W'(i)) begin
                    entry[i]      <= dispatch;
                    entry[i].src1 <= dispSrc1;
                    entry[i].src2 <= dispSrc2;
                end
            end
            if (pickValid) begin
                issue.op     <= entry[pick].op;
                issue.pc     <= entry[pick].pc;
                issue.imm    <= entry[pick].imm;
                issue.rd     <= entry[pick].rd;
                issue.rs1Val <= entry[pick].src1.value;
                issue.rs2Val <= entry[pick].src2.value;
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide the outcome from the log
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module aluClusterTb -f aluCluster.f -o simAluCluster \
    && ./obj_dir/simAluCluster > sim.log 2>&1 \
    || echo "build or run stopped with an error"
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

//--- verification/aluClusterTb.sv
`timescale 1ns/100ps
`default_nettype none

module aluClusterTb;

    localparam int NUM_TAGS    = 1 << $bits(aluClusterPkg::tagT);
    localparam int TOTAL_OPS   = 36 + 18 + 4 + 8 + 4 + 24;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;

    logic                      clk;
    logic                      rst;
    logic                      rdy;
    logic                      dispatchValid;
    aluClusterPkg::dispatchT   dispatch;
    aluClusterPkg::cdbT        extCdb;
    logic                      full;
    aluClusterPkg::execResultT exec;
    aluClusterPkg::cdbT        cdbBus;

    // scoreboard, indexed by destination tag
    logic                    pending  [NUM_TAGS];
    logic                    seen     [NUM_TAGS];
    logic                    known    [NUM_TAGS];
    aluClusterPkg::dataT     knownVal [NUM_TAGS];
    aluClusterPkg::dispatchT record   [NUM_TAGS];
    aluClusterPkg::tagT      orderQ   [$];

    int                 arrivals;
    int                 dispatched;
    int                 cycles;
    int                 mismatches;
    int                 duplicates;
    int                 missing;
    int                 misorders;
    int                 fullErrors;
    int                 busErrors;
    logic               stallMode;
    logic               orderCheck;
    logic               checkValid;
    logic               execOk;
    logic               firstArrival;
    logic               inOrder;
    aluClusterPkg::tagT checkTag;

    aluCluster UUT (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .extCdb        (extCdb),
        .full          (full),
        .exec          (exec),
        .cdbBus        (cdbBus)
    );

    bind aluCluster aluClusterAsserts checks (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .dispatchValid (dispatchValid),
        .full          (full),
        .issueValid    (issueValid),
        .exec          (exec)
    );

    // RV32I semantics for the operations the cluster executes
    function automatic aluClusterPkg::execResultT expectedResult(aluClusterPkg::dispatchT d,
                                                                 aluClusterPkg::dataT a,
                                                                 aluClusterPkg::dataT b);
        aluClusterPkg::execResultT r;
        logic                      taken;
        taken       = 1'b0;
        r.cdb.valid = 1'b1;
        r.cdb.tag   = d.rd;
        r.cdb.value = '0;
        r.jump      = 1'b0;
        r.nextPc    = d.pc + 32'd4;
        case (d.op)
            aluClusterPkg::OP_LUI:   r.cdb.value = d.imm;
            aluClusterPkg::OP_AUIPC: r.cdb.value = d.pc + d.imm;
            aluClusterPkg::OP_JAL: begin
                r.cdb.value = d.pc + 32'd4;
                r.jump      = 1'b1;
                r.nextPc    = d.pc + d.imm;
            end
            aluClusterPkg::OP_JALR: begin
                r.cdb.value = d.pc + 32'd4;
                r.jump      = 1'b1;
                r.nextPc    = (a + d.imm) & 32'hffff_fffe;
            end
            aluClusterPkg::OP_BEQ:   taken = (a == b);
            aluClusterPkg::OP_BNE:   taken = (a != b);
            aluClusterPkg::OP_BLT:   taken = ($signed(a) < $signed(b));
            aluClusterPkg::OP_BGE:   taken = !($signed(a) < $signed(b));
            aluClusterPkg::OP_BLTU:  taken = (a < b);
            aluClusterPkg::OP_BGEU:  taken = !(a < b);
            aluClusterPkg::OP_ADDI:  r.cdb.value = a + d.imm;
            aluClusterPkg::OP_SLTI:  r.cdb.value = {31'd0, $signed(a) < $signed(d.imm)};
            aluClusterPkg::OP_SLTIU: r.cdb.value = {31'd0, a < d.imm};
            aluClusterPkg::OP_XORI:  r.cdb.value = a ^ d.imm;
            aluClusterPkg::OP_ORI:   r.cdb.value = a | d.imm;
            aluClusterPkg::OP_ANDI:  r.cdb.value = a & d.imm;
            aluClusterPkg::OP_SLLI:  r.cdb.value = a << d.imm[4:0];
            aluClusterPkg::OP_SRLI:  r.cdb.value = a >> d.imm[4:0];
            aluClusterPkg::OP_SRAI:  r.cdb.value = $signed(a) >>> d.imm[4:0];
            aluClusterPkg::OP_ADD:   r.cdb.value = a + b;
            aluClusterPkg::OP_SUB:   r.cdb.value = a - b;
            aluClusterPkg::OP_SLL:   r.cdb.value = a << b[4:0];
            aluClusterPkg::OP_SLT:   r.cdb.value = {31'd0, $signed(a) < $signed(b)};
            aluClusterPkg::OP_SLTU:  r.cdb.value = {31'd0, a < b};
            aluClusterPkg::OP_XOR:   r.cdb.value = a ^ b;
            aluClusterPkg::OP_SRL:   r.cdb.value = a >> b[4:0];
            aluClusterPkg::OP_SRA:   r.cdb.value = $signed(a) >>> b[4:0];
            aluClusterPkg::OP_OR:    r.cdb.value = a | b;
            aluClusterPkg::OP_AND:   r.cdb.value = a & b;
            default:                 r.cdb.value = '0;
        endcase
        if (taken) begin
            r.jump   = 1'b1;
            r.nextPc = d.pc + d.imm;
        end
        return r;
    endfunction

    function automatic aluClusterPkg::dataT operandValue(aluClusterPkg::operandT src);
        return src.ready ? src.value : knownVal[src.tag];
    endfunction

    function automatic aluClusterPkg::operandT readyOpnd(aluClusterPkg::dataT v);
        return '{ready: 1'b1, tag: '0, value: v};
    endfunction

    function automatic aluClusterPkg::operandT waitOpnd(int tag);
        return '{ready: 1'b0, tag: aluClusterPkg::tagT'(tag), value: '0};
    endfunction

    task automatic sendOp(aluClusterPkg::aluOpT op, int rd, aluClusterPkg::operandT s1,
                          aluClusterPkg::operandT s2, aluClusterPkg::dataT imm);
        aluClusterPkg::dispatchT d;
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        @(posedge clk);
        // a producer that already finished is handed over as a value, as rename would
        if (!s1.ready && known[s1.tag]) begin
            s1 = readyOpnd(knownVal[s1.tag]);
        end
        if (!s2.ready && known[s2.tag]) begin
            s2 = readyOpnd(knownVal[s2.tag]);
        end
        d.op       = op;
        d.pc       = aluClusterPkg::addrT'($urandom) & 32'hffff_fffc;
        d.imm      = imm;
        d.rd       = aluClusterPkg::tagT'(rd);
        d.src1     = s1;
        d.src2     = s2;
        record[rd]  = d;
        pending[rd] = 1'b1;
        dispatched++;
        if (orderCheck) begin
            orderQ.push_back(d.rd);
        end
        dispatch      <= d;
        dispatchValid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rdy);
        dispatchValid <= 1'b0;
    endtask

    task automatic broadcastExt(int tag, aluClusterPkg::dataT value);
        @(posedge clk);
        extCdb <= '{valid: 1'b1, tag: aluClusterPkg::tagT'(tag), value: value};
        do begin
            @(posedge clk);
        end while (!rdy);
        extCdb.valid <= 1'b0;
    endtask

    task automatic finishPhase();
        while (arrivals < dispatched) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t] && !seen[t]) begin
                missing++;
                $display("tag %0d was dispatched but never came back", t);
            end
            pending[t] = 1'b0;
            seen[t]    = 1'b0;
            known[t]   = 1'b0;
        end
        arrivals   = 0;
        dispatched = 0;
        orderQ.delete();
    endtask

    function automatic aluClusterPkg::aluOpT randomOp();
        return aluClusterPkg::aluOpT'($urandom_range(28));
    endfunction

    // results are taken at the falling edge, where exec and the stall input are settled
    always @(negedge clk) begin
        checkValid = 1'b0;
        if (!rst) begin
            if (extCdb.valid) begin
                known[extCdb.tag]    = 1'b1;
                knownVal[extCdb.tag] = extCdb.value;
            end
            if (exec.cdb.valid && rdy) begin
                checkValid   = 1'b1;
                checkTag     = exec.cdb.tag;
                execOk       = pending[checkTag] && (exec == expectedResult(record[checkTag],
                               operandValue(record[checkTag].src1),
                               operandValue(record[checkTag].src2)));
                firstArrival = !seen[checkTag];
                seen[checkTag] = 1'b1;
                arrivals++;
                inOrder = 1'b1;
                if (orderCheck) begin
                    inOrder = (orderQ.size() != 0) && (orderQ[0] == checkTag);
                    if (orderQ.size() != 0) begin
                        void'(orderQ.pop_front());
                    end
                end
            end
            if (exec.cdb.valid) begin
                known[exec.cdb.tag]    = 1'b1;
                knownVal[exec.cdb.tag] = exec.cdb.value;
            end
        end
    end

    resultMatchesModel: assert property (@(posedge clk) disable iff (rst) checkValid |-> execOk)
        else begin
            mismatches++;
            $display("Error at %0t: tag %0d result differs from the model", $time, checkTag);
        end

    tagOnce: assert property (@(posedge clk) disable iff (rst) checkValid |-> firstArrival)
        else begin
            duplicates++;
            $display("tag %0d came back more than once", checkTag);
        end

    oldestFirst: assert property (@(posedge clk) disable iff (rst) checkValid |-> inOrder)
        else begin
            misorders++;
            $display("Error at %0t: tag %0d left out of dispatch order", $time, checkTag);
        end

    // an external result owns the merged bus, the own result fills it otherwise
    busCarriesExt: assert property (@(posedge clk) disable iff (rst)
        extCdb.valid |-> cdbBus == extCdb)
        else begin
            busErrors++;
            $display("Error at %0t: merged bus does not carry the external result", $time);
        end

    busCarriesOwn: assert property (@(posedge clk) disable iff (rst)
        !extCdb.valid |-> cdbBus === exec.cdb)
        else begin
            busErrors++;
            $display("Error at %0t: merged bus does not carry the own result", $time);
        end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        rdy <= stallMode ? ($urandom_range(3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with results still outstanding", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(5));
        rst           = 1'b1;
        rdy           = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        extCdb        = '0;
        stallMode     = 1'b0;
        orderCheck    = 1'b0;
        checkValid    = 1'b0;
        cycles        = 0;
        mismatches    = 0;
        duplicates    = 0;
        missing       = 0;
        misorders     = 0;
        fullErrors    = 0;
        busErrors     = 0;
        arrivals      = 0;
        dispatched    = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
            seen[t]    = 1'b0;
            known[t]   = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // independent operations are all ready, so they leave in dispatch order
        orderCheck = 1'b1;
        repeat (3) begin
            for (int i = 0; i < 12; i++) begin
                sendOp(randomOp(), i, readyOpnd($urandom), readyOpnd($urandom), $urandom);
            end
            finishPhase();
        end

        for (int b = 0; b < 6; b++) begin
            sendOp(aluClusterPkg::aluOpT'(int'(aluClusterPkg::OP_BEQ) + b), 3 * (b % 3),
                   readyOpnd(32'h55), readyOpnd(32'h55), 32'($urandom_range(4095)) << 1);
            sendOp(aluClusterPkg::aluOpT'(int'(aluClusterPkg::OP_BEQ) + b), 3 * (b % 3) + 1,
                   readyOpnd(32'hffff_fff0), readyOpnd(32'h10), 32'($urandom_range(4095)) << 1);
            sendOp(aluClusterPkg::aluOpT'(int'(aluClusterPkg::OP_BEQ) + b), 3 * (b % 3) + 2,
                   readyOpnd(32'h10), readyOpnd(32'hffff_fff0), 32'($urandom_range(4095)) << 1);
            if (b == 2 || b == 5) begin
                finishPhase();
            end
        end

        sendOp(aluClusterPkg::OP_JAL, 0, readyOpnd(0), readyOpnd(0), 32'h0000_0800);
        sendOp(aluClusterPkg::OP_JAL, 1, readyOpnd(0), readyOpnd(0), 32'hffff_fff8);
        sendOp(aluClusterPkg::OP_JALR, 2, readyOpnd($urandom), readyOpnd(0), 32'h0000_0124);
        sendOp(aluClusterPkg::OP_JALR, 3, readyOpnd(32'h1000), readyOpnd(0), 32'h0000_0003);
        finishPhase();

        // chains on own results and on the external bus
        orderCheck = 1'b0;
        sendOp(aluClusterPkg::OP_ADDI, 4, readyOpnd($urandom), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_ADD, 5, waitOpnd(4), waitOpnd(4), 0);
        sendOp(aluClusterPkg::OP_XOR, 6, waitOpnd(5), waitOpnd(14), 0);
        broadcastExt(14, $urandom);
        sendOp(aluClusterPkg::OP_SUB, 7, waitOpnd(6), readyOpnd($urandom), 0);
        finishPhase();

        // tag 3 wakes from its own tag 0 and external tag 13 in the same cycle
        sendOp(aluClusterPkg::OP_ADDI, 0, waitOpnd(12), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_ORI, 1, waitOpnd(12), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_SLLI, 2, waitOpnd(12), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_AND, 3, waitOpnd(0), waitOpnd(13), 0);
        broadcastExt(12, $urandom);
        @(posedge clk);
        broadcastExt(13, $urandom);
        finishPhase();

        // a burst that fills the station, then wakes every entry at once
        orderCheck = 1'b1;
        sendOp(aluClusterPkg::OP_ADDI, 0, waitOpnd(15), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_XORI, 1, waitOpnd(15), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_SRAI, 2, waitOpnd(15), readyOpnd(0), $urandom);
        sendOp(aluClusterPkg::OP_SLTI, 3, waitOpnd(15), readyOpnd(0), $urandom);
        @(negedge clk);
        assert (full) else begin
            fullErrors++;
            $display("Error at %0t: station did not report full while holding four entries",
                     $time);
        end
        broadcastExt(15, $urandom);
        finishPhase();

        stallMode = 1'b1;
        repeat (2) begin
            for (int i = 0; i < 12; i++) begin
                sendOp(randomOp(), i, readyOpnd($urandom), readyOpnd($urandom), $urandom);
            end
            finishPhase();
        end
        stallMode = 1'b0;

        repeat (2) @(posedge clk);
        $write("checks done: %0d mismatches, %0d duplicates, %0d missing, ",
               mismatches, duplicates, missing);
        $display("%0d out of order, %0d full, %0d bus", misorders, fullErrors, busErrors);
        if (mismatches + duplicates + missing + misorders + fullErrors + busErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/aluCluster_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module aluClusterAsserts (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      rdy,
    input wire logic                      dispatchValid,
    input wire logic                      full,
    input wire logic                      issueValid,
    input wire aluClusterPkg::execResultT exec
);

    resetClearsValid: assert property (@(posedge clk) rst |=> !exec.cdb.valid)
        else $error("result valid seen during or right after reset");

    // the source must hold off while the station is full
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        full |-> !dispatchValid)
        else $error("dispatch offered while the station was full");

    stallFreezes: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> $stable(exec) && $stable(full))
        else $error("outputs changed across a stalled cycle");

    // one cycle of execute latency, no more and no less
    resultFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        rdy |=> exec.cdb.valid == $past(issueValid))
        else $error("result valid did not follow the issue by exactly one cycle");

endmodule

`default_nettype wire
